// ==== testbench/ldstUnitPatterns.txt ====
# Columns: op (0 load, 1 store) base stride length fill tag holdFlag burstFlag, all hex
# The seed line gives the initial memory contents, word i holds i XOR seed
seed 5a5a0000
# Strided loads, one wrapping past the top of memory
0 0000 0001 0008 00000000 1 0 0
0 0010 0003 0006 00000000 2 0 0
0 00f0 0007 0005 00000000 3 0 0
# Stores followed by overlapping loads
1 0020 0002 0004 cafe0001 4 0 0
0 001e 0001 000c 00000000 5 0 0
1 00fe 0003 0003 0badf00d 6 0 0
0 0000 0001 0006 00000000 7 0 0
# Length zero requests
0 0030 0001 0000 00000000 8 0 0
1 0040 0004 0000 11111111 9 0 0
# Random hold while walking
0 0005 0011 0010 00000000 a 1 0
1 0050 0001 0003 deadbeef b 1 0
0 004e 0001 0008 00000000 c 1 0
0 0100 00ff 0007 00000000 d 1 0
# Burst under sustained hold, longer than the queue
0 0060 0002 0003 00000000 e 0 1
1 0061 0002 0002 a5a50001 f 0 1
0 0060 0001 0004 00000000 0 0 1
0 0070 0005 0002 00000000 1 0 1
1 0072 0001 0003 a5a50002 2 0 1
0 0070 0001 0006 00000000 3 0 1
0 0080 0000 0003 00000000 4 0 1
1 0090 0010 0002 a5a50003 5 0 1
0 0090 0010 0003 00000000 6 0 1
0 00a0 0001 0000 00000000 7 0 1
0 00b0 0003 0004 00000000 8 0 1

// ==== all.f ====
src/ldstPkg.sv
src/ringBuffCtrl.sv
src/ldstTokenQueue.sv
src/strideAddrGen.sv
src/dataMem.sv
src/ldstUnit.sv
testbench/ldstUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the load/store unit testbench with Verilator, run it and look for the pass line
verilator --binary --timing -Wno-fatal -f all.f --top-module ldstUnitTb -o ldstUnitSim \
	&& ./obj_dir/ldstUnitSim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== testbench/ldstUnitTb.sv ====
// Testbench for the load/store unit
// Pattern reader, reference memory model, output checker and watchdog

`timescale 1ns/1ps

module ldstUnitTb;

	localparam int DEPTH_BUFF	= 8;
	localparam int MEM_WORDS	= 256;
	localparam int MAX_REQ		= 64;

	logic						clock;
	logic						rst;
	logic						reqValid;
	ldstPkg::ldstReq_t			req;
	logic						hold;
	logic						stall;
	logic						empty;
	logic						loadValid;
	ldstPkg::loadResult_t		loadResult;
	logic						done;
	ldstPkg::tag_t				doneTag;

	//////////////////////////////////////////////////
	// Stimulus and model state

	ldstPkg::ldstReq_t			reqList [MAX_REQ];		// Requests from the pattern file
	logic						holdFlag [MAX_REQ];		// Random hold while offered
	logic						burstFlag [MAX_REQ];	// Part of a sustained hold burst
	int							numReq;
	int							totalElems;
	ldstPkg::data_t				memSeed;				// Initial word i is i ^ seed
	ldstPkg::data_t				modelMem [MEM_WORDS];
	ldstPkg::loadResult_t		loadQ [$];				// Expected load words
	ldstPkg::tag_t				doneQ [$];				// Expected done tags
	int							seed;
	logic						burstHold;
	logic						randMode;
	logic						sawStall;
	logic						inBurst;
	logic						checking	= 1'b0;
	logic						loaded		= 1'b0;

	ldstUnit #(
		.DEPTH_BUFF	(DEPTH_BUFF),
		.MEM_WORDS	(MEM_WORDS)
	) ldstUnit_inst (
		.clock		(clock),
		.rst		(rst),
		.reqValid	(reqValid),
		.req		(req),
		.hold		(hold),
		.stall		(stall),
		.empty		(empty),
		.loadValid	(loadValid),
		.loadResult	(loadResult),
		.done		(done),
		.doneTag	(doneTag)
	);

	always #4 clock = ~clock;							// 8 ns period

	//////////////////////////////////////////////////
	// Reporting

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] gotVal,
			input logic [63:0] expVal);
		if (gotVal !== expVal) begin
			failRun($sformatf("MISMATCH time %0t signal %s got %0h expected %0h",
				$time, name, gotVal, expVal));
		end
	endtask

	//////////////////////////////////////////////////
	// Pattern file and reference model

	task automatic readPatterns();
		int		fd;
		int		code;
		int		f [8];
		string	line;
		fd = $fopen("testbench/ldstUnitPatterns.txt", "r");
		if (fd == 0) begin
			failRun("could not open testbench/ldstUnitPatterns.txt");
		end
		numReq		= 0;
		totalElems	= 0;
		memSeed		= '0;
		while (!$feof(fd)) begin
			line	= "";
			code	= $fgets(line, fd);
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;								// Blank or comment
			end
			if (line.substr(0, 3) == "seed") begin
				code	= $sscanf(line, "seed %h", memSeed);
			end else if (numReq < MAX_REQ) begin
				code	= $sscanf(line, "%h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
				if (code != 8) begin
					failRun("malformed request line in the pattern file");
				end
				reqList[numReq].op		= ldstPkg::accessOp_t'(f[0] & 1);
				reqList[numReq].base	= ldstPkg::address_t'(f[1]);
				reqList[numReq].stride	= ldstPkg::address_t'(f[2]);
				reqList[numReq].length	= ldstPkg::address_t'(f[3]);
				reqList[numReq].fill	= ldstPkg::data_t'(f[4]);
				reqList[numReq].tag		= ldstPkg::tag_t'(f[5]);
				holdFlag[numReq]		= (f[6] != 0);
				burstFlag[numReq]		= (f[7] != 0);
				totalElems				= totalElems + (f[3] & 32'hffff);
				numReq					= numReq + 1;
			end
		end
		$fclose(fd);
	endtask

	// Applies one accepted request in order, queueing what the DUT must return
	task automatic modelRequest(input ldstPkg::ldstReq_t r);
		int						addr;
		ldstPkg::loadResult_t	res;
		for (int i = 0; i < int'(r.length); i++) begin
			addr	= int'((longint'(r.base) + longint'(i) * longint'(r.stride)) % MEM_WORDS);
			if (r.op == ldstPkg::opStore) begin
				modelMem[addr]	= r.fill;
			end else begin
				res.data	= modelMem[addr];
				res.tag		= r.tag;
				res.last	= (i == int'(r.length) - 1);	// Only final element
				loadQ.push_back(res);
			end
		end
		doneQ.push_back(r.tag);
	endtask

	//////////////////////////////////////////////////
	// Driving

	// Next edge plus drive delay, then refresh hold
	task automatic nextCycle();
		int		rnd;
		@(posedge clock);
		#1;
		rnd		= $random(seed);
		hold	= burstHold | (randMode & rnd[0]);
	endtask

	task automatic offerRequest(input int idx);
		logic	accepted;
		accepted	= 1'b0;
		req			= reqList[idx];
		reqValid	= 1'b1;
		while (!accepted) begin
			@(negedge clock);
			if (!stall) begin
				accepted	= 1'b1;						// Taken at next edge
				modelRequest(reqList[idx]);
			end else if (burstHold) begin
				sawStall	= 1'b1;
				burstHold	= 1'b0;						// Queue full, let it drain
			end
			nextCycle();
		end
		reqValid	= 1'b0;
	endtask

	task automatic endBurst();
		checkValue("stall during burst", sawStall, 1'b1);
		burstHold	= 1'b0;
		inBurst		= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Output checker

	always @(negedge clock) begin : outputCheck
		ldstPkg::loadResult_t	expRes;
		ldstPkg::tag_t			expTag;
		if (checking) begin
			if (loadValid) begin
				if (loadQ.size() == 0) begin
					failRun($sformatf("load word at %0t with no load element outstanding", $time));
				end else begin
					expRes	= loadQ.pop_front();
					checkValue("loadResult.data", loadResult.data, expRes.data);
					checkValue("loadResult.tag", loadResult.tag, expRes.tag);
					checkValue("loadResult.last", loadResult.last, expRes.last);
				end
			end
			if (done) begin
				if (doneQ.size() == 0) begin
					failRun($sformatf("done pulse at %0t with no request outstanding", $time));
				end else begin
					expTag	= doneQ.pop_front();
					checkValue("doneTag", doneTag, expTag);	// In request order
				end
			end
		end
	end

	// Bound derived from the total work in the pattern file
	initial begin : watchdog
		int		limit;
		wait (loaded);
		limit	= 50 * (totalElems + numReq);
		repeat (limit + 8) @(posedge clock);
		failRun($sformatf("run timed out with %0d load words and %0d done pulses outstanding",
			loadQ.size(), doneQ.size()));
	end

	//////////////////////////////////////////////////
	// Main sequence

	initial begin : stimulus
		seed		= 32'h9f25d615;
		clock		= 1'b0;
		rst			= 1'b1;
		reqValid	= 1'b0;
		req			= '0;
		hold		= 1'b0;
		burstHold	= 1'b0;
		randMode	= 1'b0;
		sawStall	= 1'b0;
		inBurst		= 1'b0;
		readPatterns();
		for (int i = 0; i < MEM_WORDS; i++) begin
			modelMem[i]	= ldstPkg::data_t'(i) ^ memSeed;
		end
		loaded	= 1'b1;
		repeat (3) @(posedge clock);
		#1;
		rst		= 1'b0;
		@(negedge clock);
		checkValue("empty", empty, 1'b1);				// Idle state after reset
		checkValue("stall", stall, 1'b0);
		checkValue("loadValid", loadValid, 1'b0);
		checkValue("done", done, 1'b0);
		checking	= 1'b1;
		nextCycle();
		for (int i = 0; i < numReq; i++) begin
			if (burstFlag[i] && !inBurst) begin
				inBurst		= 1'b1;
				sawStall	= 1'b0;
				burstHold	= 1'b1;
				hold		= 1'b1;						// Block grants right away
			end else if (!burstFlag[i] && inBurst) begin
				endBurst();
			end
			randMode	= holdFlag[i];
			offerRequest(i);
		end
		if (inBurst) begin
			endBurst();
		end
		randMode	= 1'b0;
		while (loadQ.size() != 0 || doneQ.size() != 0) begin
			nextCycle();
		end
		repeat (6) nextCycle();							// Catch late extra outputs
		checkValue("empty", empty, 1'b1);				// Queue drained
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== src/ldstUnit.sv ====
// Load/store unit top level
// Request queue, strided address generator and data memory

`timescale 1ns/1ps

module ldstUnit #(
	parameter int DEPTH_BUFF	= 8,
	parameter int MEM_WORDS		= 256
)(
	input							clock,
	input							rst,
	input							reqValid,		// Request strobe
	input	ldstPkg::ldstReq_t		req,
	input							hold,			// Pause issue and grants
	output	logic					stall,			// Queue full
	output	logic					empty,			// Queue empty
	output	logic					loadValid,
	output	ldstPkg::loadResult_t	loadResult,
	output	logic					done,
	output	ldstPkg::tag_t			doneTag
);

	//////////////////////////////////////////////////
	// Internal nets

	logic								headValid;
	ldstPkg::ldstReq_t					head;
	logic								grant;
	logic								memEn;
	logic								memWe;
	logic [$clog2(MEM_WORDS)-1:0]		memAddr;
	ldstPkg::data_t						memWData;
	ldstPkg::data_t						memRData;

	ldstTokenQueue #(
		.DEPTH_BUFF	(DEPTH_BUFF)
	) ldstTokenQueue_inst (
		.clock		(clock),
		.rst		(rst),
		.hold		(hold),
		.reqValid	(reqValid),
		.req		(req),
		.grant		(grant),
		.headValid	(headValid),
		.head		(head),
		.stall		(stall),
		.empty		(empty)
	);

	strideAddrGen #(
		.MEM_WORDS	(MEM_WORDS)
	) strideAddrGen_inst (
		.clock		(clock),
		.rst		(rst),
		.hold		(hold),
		.headValid	(headValid),
		.head		(head),
		.memRData	(memRData),
		.grant		(grant),
		.memEn		(memEn),
		.memWe		(memWe),
		.memAddr	(memAddr),
		.memWData	(memWData),
		.loadValid	(loadValid),
		.loadResult	(loadResult),
		.done		(done),
		.doneTag	(doneTag)
	);

	dataMem #(
		.MEM_WORDS	(MEM_WORDS)
	) dataMem_inst (
		.clock		(clock),
		.memEn		(memEn),
		.memWe		(memWe),
		.memAddr	(memAddr),
		.memWData	(memWData),
		.memRData	(memRData)
	);

endmodule

// ==== src/dataMem.sv ====
// Single-port word memory
// Synchronous write, registered read with one-cycle latency

`timescale 1ns/1ps

module dataMem #(
	parameter int MEM_WORDS	= 256
)(
	input									clock,
	input									memEn,		// Access this cycle
	input									memWe,		// Write when set, else read
	input	[$clog2(MEM_WORDS)-1:0]			memAddr,
	input	ldstPkg::data_t					memWData,
	output	ldstPkg::data_t					memRData	// Valid the cycle after a read
);

	//////////////////////////////////////////////////
	// Array

	ldstPkg::data_t		mem [MEM_WORDS];

	// Known start pattern, word i holds i ^ 5A5A0000
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i]	= ldstPkg::data_t'(i) ^ 32'h5A5A0000;
		end
	end

	//////////////////////////////////////////////////
	// Port

	always_ff @(posedge clock) begin
		if (memEn) begin
			if (memWe) begin
				mem[memAddr]	<= memWData;		// Read output untouched
			end else begin
				memRData		<= mem[memAddr];
			end
		end
	end

endmodule

// ==== src/strideAddrGen.sv ====
// Strided address generator
// Walks one request over memory, returns load words and signals completion

`timescale 1ns/1ps

module strideAddrGen #(
	parameter int MEM_WORDS	= 256
)(
	input										clock,
	input										rst,
	input										hold,		// Pause element issue
	input										headValid,
	input	ldstPkg::ldstReq_t					head,
	input	ldstPkg::data_t						memRData,	// Read data, one cycle late
	output	logic								grant,		// Pops queue head
	output	logic								memEn,
	output	logic								memWe,
	output	logic [$clog2(MEM_WORDS)-1:0]		memAddr,
	output	ldstPkg::data_t						memWData,
	output	logic								loadValid,
	output	ldstPkg::loadResult_t				loadResult,
	output	logic								done,		// End of request
	output	ldstPkg::tag_t						doneTag
);

	localparam int AW	= $clog2(MEM_WORDS);

	//////////////////////////////////////////////////
	// Request state

	ldstPkg::genState_t		state;
	ldstPkg::accessOp_t		curOp;					// Latched opcode
	logic [AW-1:0]			curAddr;				// Element address, wraps
	logic [AW-1:0]			curStride;
	ldstPkg::address_t		remain;					// Elements left to issue
	ldstPkg::data_t			curFill;
	ldstPkg::tag_t			curTag;

	logic					issue;
	logic					lastIssue;

	// Read return alignment
	logic					rdPending;
	ldstPkg::tag_t			rdTag;
	logic					rdLast;

	assign grant		= (state == ldstPkg::genIdle) & headValid;
	assign issue		= (state == ldstPkg::genRun) & ~hold;	// Run always has work left
	assign lastIssue	= issue & (remain == ldstPkg::address_t'(1));

	//////////////////////////////////////////////////
	// FSM and control

	always_ff @(posedge clock) begin
		if (rst) begin
			state		<= ldstPkg::genIdle;
			rdPending	<= 1'b0;
			done		<= 1'b0;
		end else begin
			rdPending	<= issue & (curOp == ldstPkg::opLoad);
			done		<= (grant & (head.length == '0)) | lastIssue;	// Cycle after last access
			case (state)
				ldstPkg::genIdle: begin
					if (grant && head.length != '0) begin
						state	<= ldstPkg::genRun;
					end
				end
				ldstPkg::genRun: begin
					if (lastIssue) begin
						state	<= ldstPkg::genIdle;	// Idle while done shows
					end
				end
				default: state <= ldstPkg::genIdle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Payload registers

	always_ff @(posedge clock) begin
		if (grant) begin
			curOp		<= head.op;
			curAddr		<= head.base[AW-1:0];
			curStride	<= head.stride[AW-1:0];
			remain		<= head.length;
			curFill		<= head.fill;
			curTag		<= head.tag;
		end else if (issue) begin
			curAddr		<= curAddr + curStride;		// Modulo MEM_WORDS
			remain		<= remain - 1'b1;
		end
		if (issue) begin
			rdTag		<= curTag;
			rdLast		<= lastIssue;
		end
		if (grant & (head.length == '0)) begin
			doneTag		<= head.tag;				// Empty request
		end else if (lastIssue) begin
			doneTag		<= curTag;
		end
	end

	//////////////////////////////////////////////////
	// Outputs

	assign memEn		= issue;
	assign memWe		= issue & (curOp == ldstPkg::opStore);
	assign memAddr		= curAddr;
	assign memWData		= curFill;

	assign loadValid			= rdPending;
	assign loadResult.data		= memRData;
	assign loadResult.tag		= rdTag;
	assign loadResult.last		= rdLast;

endmodule

// ==== src/ldstTokenQueue.sv ====
// Load/store request queue
// Ring-buffered request storage presenting the oldest entry to the generator

`timescale 1ns/1ps

module ldstTokenQueue #(
	parameter int DEPTH_BUFF	= 8
)(
	input						clock,
	input						rst,
	input						hold,				// Masks head toward generator
	input						reqValid,			// Incoming request strobe
	input	ldstPkg::ldstReq_t	req,				// Incoming request
	input						grant,				// Pops the head
	output	logic				headValid,			// Head may be taken
	output	ldstPkg::ldstReq_t	head,				// Oldest request
	output	logic				stall,				// Queue full, source must hold
	output	logic				empty				// Nothing buffered
);

	localparam int WIDTH_BUFF	= $clog2(DEPTH_BUFF);

	//////////////////////////////////////////////////
	// Storage

	ldstPkg::ldstReq_t			buff [DEPTH_BUFF];	// Request slots, no reset

	logic						we;
	logic						re;
	logic [WIDTH_BUFF-1:0]		wPtr;
	logic [WIDTH_BUFF-1:0]		rPtr;
	logic						full;

	assign we	= reqValid & ~full;					// Lost if full
	assign re	= grant;							// Generator only grants a valid head

	always_ff @(posedge clock) begin
		if (we) begin
			buff[wPtr]	<= req;
		end
	end

	//////////////////////////////////////////////////
	// Outputs

	assign head			= buff[rPtr];
	assign headValid	= ~empty & ~hold;
	assign stall		= full;

	ringBuffCtrl #(
		.NUM_ENTRY	(DEPTH_BUFF)
	) ringBuffCtrl_inst (
		.clock		(clock),
		.rst		(rst),
		.we			(we),
		.re			(re),
		.wAddr		(wPtr),
		.rAddr		(rPtr),
		.full		(full),
		.empty		(empty),
		.num		()
	);

	//////////////////////////////////////////////////
	// Checks

	// Generator may only pop a presented head
	assert property (@(posedge clock) disable iff (rst) grant |-> headValid)
		else $error("ldstTokenQueue: grant without valid head");

endmodule

// ==== src/ringBuffCtrl.sv ====
// Ring buffer pointer control
// Read/write pointers, occupancy count, full and empty flags

`timescale 1ns/1ps

module ringBuffCtrl #(
	parameter int NUM_ENTRY	= 8
)(
	input									clock,
	input									rst,
	input									we,			// Push one entry
	input									re,			// Pop one entry
	output	logic [$clog2(NUM_ENTRY)-1:0]	wAddr,		// Next slot to write
	output	logic [$clog2(NUM_ENTRY)-1:0]	rAddr,		// Oldest slot
	output	logic							full,
	output	logic							empty,
	output	logic [$clog2(NUM_ENTRY):0]		num			// Occupancy
);

	localparam int WIDTH	= $clog2(NUM_ENTRY);

	//////////////////////////////////////////////////
	// Pointers and counter

	always_ff @(posedge clock) begin
		if (rst) begin
			wAddr	<= '0;
			rAddr	<= '0;
			num		<= '0;
		end else begin
			if (we) begin
				wAddr	<= wAddr + 1'b1;			// Wraps at power of two
			end
			if (re) begin
				rAddr	<= rAddr + 1'b1;
			end
			case ({we, re})
				2'b10:		num <= num + 1'b1;
				2'b01:		num <= num - 1'b1;
				default:	num <= num;				// Both or neither
			endcase
		end
	end

	assign full		= (num == (WIDTH + 1)'(NUM_ENTRY));
	assign empty	= (num == '0);

	//////////////////////////////////////////////////
	// Checks on the callers

	// Writer must respect full
	assert property (@(posedge clock) disable iff (rst) we |-> !full)
		else $error("ringBuffCtrl: push while full");

	// Reader must respect empty
	assert property (@(posedge clock) disable iff (rst) re |-> !empty)
		else $error("ringBuffCtrl: pop while empty");

endmodule

// ==== src/ldstPkg.sv ====
// Shared types for the vector load/store path
// Data and address words, request and load-result structs, opcode and FSM enums

package ldstPkg;

	//////////////////////////////////////////////////
	// Basic words

	typedef logic [31:0]	data_t;				// Memory data word
	typedef logic [15:0]	address_t;			// Word address, stride, length
	typedef logic [3:0]		tag_t;				// Token tag

	//////////////////////////////////////////////////
	// Enums

	typedef enum logic {
		opLoad,									// Read elements back
		opStore									// Write fill to elements
	} accessOp_t;

	typedef enum logic {
		genIdle,								// Waiting for a head request
		genRun									// Walking elements
	} genState_t;

	//////////////////////////////////////////////////
	// Structs

	// One strided access request as it sits in the queue
	typedef struct packed {
		accessOp_t		op;						// Load or store
		address_t		base;					// First element address
		address_t		stride;					// Step between elements
		address_t		length;					// Element count
		data_t			fill;					// Store value
		tag_t			tag;					// Token tag
	} ldstReq_t;

	// One returned load element
	typedef struct packed {
		data_t			data;					// Word read from memory
		tag_t			tag;					// Owning request tag
		logic			last;					// Final element of request
	} loadResult_t;

endpackage
